//--- hdl/ufiArbiter.sv
// One grant per cycle among enabled heads; cmd is registered, so the RAM sees it one cycle after the grant
`timescale 1ns/1ns

module ufiArbiter
	import ufiPkg::*;
(
	input  logic                   iUfiClk,
	input  logic                   rstN,
	input  ufiReq_t                heads [lpMasterNum],
	input  logic [lpMasterNum-1:0] cfgEnable,
	input  ufiArbMode_e            cfgMode,
	output logic [lpMasterNum-1:0] grant,
	output ufiCmd_t                cmd
);

	logic [lpMasterNum-1:0]     reqMask;    // Valid and enabled
	logic [lpMasterIdWidth-1:0] startIdx;   // First master to look at
	logic [lpMasterIdWidth-1:0] idx;
	logic                       found;
	ufiMaster_e                 winner;
	ufiMaster_e                 lastGrant;  // Round robin pointer
	logic                       cmdValid;
	ufiCmd_t                    cmdPay;     // Registered payload fields

	//--------------------------------------------------
	// Request mask
	//--------------------------------------------------
	always_comb
	begin
		for (int m = 0; m < lpMasterNum; m++)
		begin
			reqMask[m] = heads[m].valid & cfgEnable[m];   // Disabled heads wait
		end
	end

	// Fixed mode starts at mcs and round robin just past the last winner
	assign startIdx = (cfgMode == arbRoundRobin) ? lastGrant + 1'b1 : '0;

	//--------------------------------------------------
	// First hit from startIdx wins
	//--------------------------------------------------
	always_comb
	begin
		found  = 1'b0;
		winner = mcsM;
		idx    = '0;
		for (int i = 0; i < lpMasterNum; i++)
		begin
			idx = lpMasterIdWidth'(int'(startIdx) + i);   // Wraps around
			if (!found && reqMask[idx])
			begin
				found  = 1'b1;
				winner = ufiMaster_e'(idx);
			end
		end
	end

	// One-hot grant popping the winning queue on this edge
	always_comb
	begin
		grant         = '0;
		grant[winner] = found;
	end

	//--------------------------------------------------
	// Command register
	//--------------------------------------------------
	always_ff @(posedge iUfiClk or negedge rstN)
	begin
		if (!rstN)
		begin
			cmdValid  <= 1'b0;
			lastGrant <= atbM;   // So mcs is first after reset
		end
		else
		begin
			cmdValid <= found;
			if (found)
				lastGrant <= winner;
		end
	end

	always_ff @(posedge iUfiClk)
	begin
		if (found)
		begin
			cmdPay <= '{valid: 1'b1,
			            op:    heads[winner].op,
			            adrs:  heads[winner].adrs,
			            wdata: heads[winner].wdata,
			            id:    winner};
		end
	end

	// Valid from the reset flop and the rest from payload
	always_comb
	begin
		cmd       = cmdPay;
		cmd.valid = cmdValid;
	end

endmodule

//--- hdl/ufiConfigRegs.sv
// Enable mask and arbitration mode; a write lands on the sampling edge, only data bit 0 sets the mode
`timescale 1ns/1ns

module ufiConfigRegs
	import ufiPkg::*;
(
	input  logic                   iUfiClk,
	input  logic                   rstN,
	input  ufiCfgWr_t              cfgWr,
	output logic [lpMasterNum-1:0] cfgEnable,
	output ufiArbMode_e            cfgMode
);

	//--------------------------------------------------
	// Register decode
	//--------------------------------------------------
	always_ff @(posedge iUfiClk or negedge rstN)
	begin
		if (!rstN)
		begin
			cfgEnable <= '1;          // All masters on
			cfgMode   <= arbFixed;    // mcs first
		end
		else if (cfgWr.valid)
		begin
			if (cfgWr.addr == 1'b0)
			begin
				cfgEnable <= cfgWr.data;                   // One bit per master
			end
			else
			begin
				cfgMode <= ufiArbMode_e'(cfgWr.data[0]);   // Upper bits ignored
			end
		end
	end

	// Read-back is the register itself, the arbiter sees the same value

endmodule

//--- hdl/ufiHub.sv
// Hub top; each master must follow the credit rule, uncontended read latency is four cycles
`timescale 1ns/1ns

module ufiHub
	import ufiPkg::*;
(
	input  logic                   iUfiClk,
	input  logic                   rstN,
	input  ufiReq_t                mReq [lpMasterNum],
	output logic [lpMasterNum-1:0] mCredit,
	output ufiRsp_t                mRsp [lpMasterNum],
	input  ufiCfgWr_t              cfgWr,
	output logic [lpMasterNum-1:0] cfgEnable,
	output ufiArbMode_e            cfgMode
);

	ufiReq_t                heads [lpMasterNum];   // Queue heads
	logic [lpMasterNum-1:0] grant;
	ufiCmd_t                cmd;                   // Registered RAM command
	logic                   rdValid;
	logic [lpDataWidth-1:0] rdData;

	//--------------------------------------------------
	// Request side
	//--------------------------------------------------
	for (genvar m = 0; m < lpMasterNum; m++)
	begin : gQueue
		ufiReqQueue ufiReqQueue_inst (
			.iUfiClk (iUfiClk),
			.rstN    (rstN),
			.req     (mReq[m]),
			.head    (heads[m]),
			.grant   (grant[m]),
			.credit  (mCredit[m])
		);
	end

	ufiConfigRegs ufiConfigRegs_inst (
		.iUfiClk   (iUfiClk),
		.rstN      (rstN),
		.cfgWr     (cfgWr),
		.cfgEnable (cfgEnable),
		.cfgMode   (cfgMode)
	);

	ufiArbiter ufiArbiter_inst (
		.iUfiClk   (iUfiClk),
		.rstN      (rstN),
		.heads     (heads),
		.cfgEnable (cfgEnable),
		.cfgMode   (cfgMode),
		.grant     (grant),
		.cmd       (cmd)
	);

	//--------------------------------------------------
	// RAM and read return
	//--------------------------------------------------
	ufiRamSlave ufiRamSlave_inst (
		.iUfiClk (iUfiClk),
		.rstN    (rstN),
		.cmd     (cmd),
		.rdValid (rdValid),
		.rdData  (rdData)
	);

	ufiReadRouter ufiReadRouter_inst (
		.iUfiClk (iUfiClk),
		.rstN    (rstN),
		.cmd     (cmd),
		.rdValid (rdValid),
		.rdData  (rdData),
		.mRsp    (mRsp)
	);

endmodule

//--- hdl/ufiPkg.sv
// Shared hub definitions; master, queue and ID queue counts must stay powers of two, queues at least 2 deep
package ufiPkg;

	//--------------------------------------------------
	// Sizes
	//--------------------------------------------------
	localparam int lpDataWidth    = 8;                       // RAM word
	localparam int lpAdrsWidth    = 10;                      // 1024 words
	localparam int lpRamDepth     = 1 << lpAdrsWidth;
	localparam int lpMasterNum    = 4;                       // mcs, spi, vtb, atb
	localparam int lpCreditNum    = 2;                       // Credits per master, also queue depth
	localparam int lpIdQueueDepth = 4;                       // RAM latency plus one register

	// Derived pointer widths
	localparam int lpMasterIdWidth = $clog2(lpMasterNum);
	localparam int lpQueuePtrWidth = $clog2(lpCreditNum);
	localparam int lpIdPtrWidth    = $clog2(lpIdQueueDepth);

	//--------------------------------------------------
	// Enums
	//--------------------------------------------------
	// Lower value wins in fixed priority
	typedef enum logic [lpMasterIdWidth-1:0] {
		mcsM,
		spiM,
		vtbM,
		atbM
	} ufiMaster_e;

	typedef enum logic {
		opRead,
		opWrite
	} ufiOp_e;

	typedef enum logic {
		arbFixed,
		arbRoundRobin
	} ufiArbMode_e;

	//--------------------------------------------------
	// Bus structs
	//--------------------------------------------------
	typedef struct packed {
		logic                   valid;
		ufiOp_e                 op;
		logic [lpAdrsWidth-1:0] adrs;
		logic [lpDataWidth-1:0] wdata;
	} ufiReq_t;

	typedef struct packed {
		logic                   valid;
		ufiOp_e                 op;
		logic [lpAdrsWidth-1:0] adrs;
		logic [lpDataWidth-1:0] wdata;
		ufiMaster_e             id;      // Requesting master
	} ufiCmd_t;

	typedef struct packed {
		logic                   valid;   // One cycle per read
		logic [lpDataWidth-1:0] rdata;
	} ufiRsp_t;

	typedef struct packed {
		logic                   valid;
		logic                   addr;    // 0 enable mask, 1 arbitration mode
		logic [lpMasterNum-1:0] data;
	} ufiCfgWr_t;

endpackage

//--- hdl/ufiRamSlave.sv
// Behavioral single-port RAM; writes land on the command edge, reads return two edges later in order
`timescale 1ns/1ns

module ufiRamSlave
	import ufiPkg::*;
(
	input  logic                   iUfiClk,
	input  logic                   rstN,
	input  ufiCmd_t                cmd,
	output logic                   rdValid,
	output logic [lpDataWidth-1:0] rdData
);

	logic [lpDataWidth-1:0] mem [lpRamDepth];   // Contents undefined after power up
	logic [lpDataWidth-1:0] rdData1;            // First read stage
	logic                   rdValid1;

	//--------------------------------------------------
	// Array access and data pipe
	//--------------------------------------------------
	always_ff @(posedge iUfiClk)
	begin
		if (cmd.valid && cmd.op == opWrite)
			mem[cmd.adrs] <= cmd.wdata;
		rdData1 <= mem[cmd.adrs];   // Read every cycle, used only with valid
		rdData  <= rdData1;         // Second stage
	end

	// Valid pipe follows the data
	always_ff @(posedge iUfiClk or negedge rstN)
	begin
		if (!rstN)
		begin
			rdValid1 <= 1'b0;
			rdValid  <= 1'b0;
		end
		else
		begin
			rdValid1 <= cmd.valid && (cmd.op == opRead);
			rdValid  <= rdValid1;
		end
	end

endmodule

//--- hdl/ufiReadRouter.sv
// Steers read data by ID; relies on in-order RAM returns and never more than lpIdQueueDepth reads in flight
`timescale 1ns/1ns

module ufiReadRouter
	import ufiPkg::*;
(
	input  logic                   iUfiClk,
	input  logic                   rstN,
	input  ufiCmd_t                cmd,
	input  logic                   rdValid,
	input  logic [lpDataWidth-1:0] rdData,
	output ufiRsp_t                mRsp [lpMasterNum]
);

	ufiMaster_e              idQ [lpIdQueueDepth];   // Outstanding read IDs
	logic [lpIdPtrWidth-1:0] wrPtr;
	logic [lpIdPtrWidth-1:0] rdPtr;
	logic                    push;
	logic [lpMasterNum-1:0]  rspValid;               // One-hot per master
	logic [lpDataWidth-1:0]  rspData;                // Shared by all masters

	assign push = cmd.valid && (cmd.op == opRead);   // Same cycle RAM starts the read

	//--------------------------------------------------
	// ID queue
	//--------------------------------------------------
	always_ff @(posedge iUfiClk)
	begin
		if (push)
			idQ[wrPtr] <= cmd.id;
		if (rdValid)
			rspData <= rdData;
	end

	always_ff @(posedge iUfiClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			rspValid <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			rspValid <= '0;   // Single-cycle pulse
			if (rdValid)
			begin
				rdPtr               <= rdPtr + 1'b1;   // Pop oldest ID
				rspValid[idQ[rdPtr]] <= 1'b1;
			end
		end
	end

	//--------------------------------------------------
	// Response fan-out
	//--------------------------------------------------
	always_comb
	begin
		for (int m = 0; m < lpMasterNum; m++)
		begin
			mRsp[m] = '{valid: rspValid[m], rdata: rspData};
		end
	end

endmodule

//--- hdl/ufiReqQueue.sv
// Per-master request FIFO; the master must obey its credits, so overflow is never checked here
`timescale 1ns/1ns

module ufiReqQueue
	import ufiPkg::*;
(
	input  logic    iUfiClk,
	input  logic    rstN,
	input  ufiReq_t req,     // Master request spending one credit
	output ufiReq_t head,    // Oldest entry to arbiter
	input  logic    grant,   // Pop head
	output logic    credit   // One pulse per pop
);

	ufiReq_t                    mem [lpCreditNum];   // Entry storage
	logic [lpQueuePtrWidth-1:0] wrPtr;
	logic [lpQueuePtrWidth-1:0] rdPtr;
	logic [lpQueuePtrWidth:0]   count;               // 0 .. lpCreditNum
	logic                       grantQ;              // Pop seen last edge

	//--------------------------------------------------
	// Entry storage write
	//--------------------------------------------------
	always_ff @(posedge iUfiClk)
	begin
		if (req.valid)
		begin
			mem[wrPtr] <= req;
		end
	end

	//--------------------------------------------------
	// Pointers, count and credit return
	//--------------------------------------------------
	always_ff @(posedge iUfiClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr  <= '0;
			rdPtr  <= '0;
			count  <= '0;
			grantQ <= 1'b0;
			credit <= 1'b0;
		end
		else
		begin
			if (req.valid)
				wrPtr <= wrPtr + 1'b1;   // Wraps at depth
			if (grant)
				rdPtr <= rdPtr + 1'b1;

			case ({req.valid, grant})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // Idle or push with pop
			endcase

			// Credit leaves one cycle after the pop edge
			grantQ <= grant;
			credit <= grantQ;
		end
	end

	// Head payload from storage with valid while not empty
	always_comb
	begin
		head       = mem[rdPtr];
		head.valid = (count != '0);
	end

endmodule

//--- run.sh
#!/bin/sh
# Build the hub testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module ufiHubTb -f ufiHub.f -o ufiHubSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/ufiHubSim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation returned status $status"
	exit $status
fi

exit 0

//--- test/ufiHubTasks.svh
// Included inside ufiHubTb after its declarations; every task works on the testbench's shared state
`ifndef UFI_HUB_TASKS_SVH
`define UFI_HUB_TASKS_SVH

//--------------------------------------------------
// Random bits and helpers
//--------------------------------------------------
// Galois form with taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
	lfsrNext = s >> 1;
	if (s[0])
		lfsrNext = lfsrNext ^ 32'h8020_0003;
endfunction

function automatic logic [31:0] randBits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		v    = {v[30:0], lfsr[0]};   // One step per bit
		lfsr = lfsrNext(lfsr);
	end
	return v;
endfunction

function automatic int creditsHeld(input ufiMaster_e m);
	return lpCreditNum - spent[m] + creditRet[m];
endfunction

function automatic int readsPending();
	int n;
	n = 0;
	for (int i = 0; i < lpMasterNum; i++)
		n += expQ[i].size();
	return n;
endfunction

function automatic bit creditsHome();
	bit ok;
	ok = 1'b1;
	for (int i = 0; i < lpMasterNum; i++)
		if (creditsHeld(ufiMaster_e'(i)) != lpCreditNum)
			ok = 1'b0;
	return ok;
endfunction

task automatic failRun(input string msg);
	$display("%s", msg);
	$display("SIMULATION FAILED");
	$fatal(1, "Run stopped at first error");
endtask

//--------------------------------------------------
// Compare tasks
//--------------------------------------------------
task automatic checkRsp(input ufiMaster_e m, input ufiRsp_t exp, input ufiRsp_t act);
	if (act !== exp)
		failRun($sformatf("ERROR %s: %s response expected %h actual %h",
			curTest, m.name(), exp, act));
endtask

task automatic checkCfg(input logic [lpMasterNum-1:0] expEn, input ufiArbMode_e expMode);
	if (cfgEnable !== expEn || cfgMode !== expMode)
		failRun($sformatf("ERROR %s: config expected %b/%s actual %b/%s",
			curTest, expEn, expMode.name(), cfgEnable, cfgMode.name()));
endtask

task automatic checkCredit(input ufiMaster_e m, input int exp);
	if (creditsHeld(m) != exp)
		failRun($sformatf("ERROR %s: %s credits expected %0d actual %0d",
			curTest, m.name(), exp, creditsHeld(m)));
endtask

task automatic checkMaster(input string what, input ufiMaster_e exp, input ufiMaster_e act);
	if (act !== exp)
		failRun($sformatf("ERROR %s: %s expected %s actual %s",
			curTest, what, exp.name(), act.name()));
endtask

task automatic checkCount(input string what, input int exp, input int act);
	if (act != exp)
		failRun($sformatf("ERROR %s: %s expected %0d actual %0d", curTest, what, exp, act));
endtask

//--------------------------------------------------
// Drive and wait
//--------------------------------------------------
task automatic stageReq(input ufiMaster_e m, input ufiOp_e op,
	input logic [lpAdrsWidth-1:0] adrs, input logic [lpDataWidth-1:0] wdata);
	if (creditsHeld(m) == 0)
		failRun($sformatf("%s: master %s tried to send without a credit", curTest, m.name()));
	spent[m]++;
	reqNext[m] = '{valid: 1'b1, op: op, adrs: adrs, wdata: wdata};
	if (op == opWrite)
	begin
		shadow[adrs]  = wdata;   // Own range per master keeps order simple
		written[adrs] = 1'b1;
	end
	else
		expQ[m].push_back(shadow[adrs]);
endtask

// One cycle of master outputs
task automatic driveCycle();
	@(posedge iUfiClk);
	#lpDriveDelay;
	for (int i = 0; i < lpMasterNum; i++)
	begin
		mReq[i]    = reqNext[i];
		reqNext[i] = '0;
	end
	drvEdge = edgeCnt + 1;
endtask

// Idle master cycle that drops any request still driven
task automatic idleCycle();
	@(posedge iUfiClk);
	#lpDriveDelay;
	for (int i = 0; i < lpMasterNum; i++)
		mReq[i] = '0;
endtask

task automatic writeCfg(input logic addr, input logic [lpMasterNum-1:0] data);
	@(posedge iUfiClk);
	#lpDriveDelay;
	cfgWr = '{valid: 1'b1, addr: addr, data: data};
	@(posedge iUfiClk);
	#lpDriveDelay;
	cfgWr = '0;   // Read-back stable after the sampling edge
endtask

// Match logged responses against the expected queues
task automatic processRsps();
	rspRec_t                rec;
	ufiMaster_e             m;
	ufiRsp_t                exp;
	while (rspSeen < rspCnt)
	begin
		rec = rspLog[rspSeen];
		m   = rec.m;
		rspSeen++;
		if (expQ[m].size() == 0)
			failRun($sformatf("%s: read data on %s with no read outstanding", curTest, m.name()));
		exp.valid = 1'b1;
		exp.rdata = expQ[m].pop_front();
		checkRsp(m, exp, rec.rsp);
		lastEdge[m] = rec.edgeNo;
		order.push_back(m);
	end
endtask

task automatic waitReads();
	int n;
	n = 0;
	processRsps();
	while (readsPending() != 0 && n < lpWaitCycles)
	begin
		idleCycle();
		processRsps();
		n++;
	end
	if (readsPending() != 0)
		failRun($sformatf("%s: read data missing after %0d cycles", curTest, lpWaitCycles));
endtask

task automatic waitCredits();
	int n;
	n = 0;
	while (!creditsHome() && n < lpWaitCycles)
	begin
		idleCycle();
		n++;
	end
	if (!creditsHome())
		failRun($sformatf("%s: credits not returned after %0d cycles", curTest, lpWaitCycles));
endtask

//--------------------------------------------------
// Directed tests
//--------------------------------------------------
task automatic testReset();
	curTest = "reset";
	repeat (4) driveCycle();
	checkCount("responses after reset", 0, rspCnt);
	checkCfg('1, arbFixed);
	writeCfg(1'b0, 4'b1010);
	checkCfg(4'b1010, arbFixed);
	writeCfg(1'b1, 4'b0001);
	checkCfg(4'b1010, arbRoundRobin);
	writeCfg(1'b0, '1);
	writeCfg(1'b1, '0);
	checkCfg('1, arbFixed);
endtask

task automatic testUncontended();
	ufiMaster_e             m;
	logic [lpAdrsWidth-1:0] a;
	curTest = "uncontended";
	for (int i = 0; i < lpMasterNum; i++)
	begin
		m = ufiMaster_e'(i);
		a = {m, 8'h10};
		stageReq(m, opWrite, a, {6'(randBits(6)), m});
		driveCycle();
		waitCredits();
		stageReq(m, opRead, a, '0);
		driveCycle();
		waitReads();
		checkCount("read latency", 4, lastEdge[m] - drvEdge);   // Edge 0 to edge 4
		waitCredits();
	end
endtask

task automatic testCredit();
	curTest = "credit flow";
	for (int k = 0; k < lpCreditNum; k++)
	begin
		stageReq(spiM, opRead, {spiM, 8'h10}, '0);
		driveCycle();
	end
	repeat (2) idleCycle();
	checkCredit(spiM, 0);      // First pulse due after edge 2
	waitCredits();
	waitReads();
endtask

task automatic testFixed();
	ufiMaster_e m;
	curTest = "fixed priority";
	for (int i = 0; i < lpMasterNum; i++)
	begin
		m = ufiMaster_e'(i);
		stageReq(m, opWrite, {m, 8'h20}, {6'(randBits(6)), m});   // Low bits keep data distinct
	end
	driveCycle();
	waitCredits();
	order.delete();
	for (int i = 0; i < lpMasterNum; i++)
	begin
		m = ufiMaster_e'(i);
		stageReq(m, opRead, {m, 8'h20}, '0);
	end
	driveCycle();
	waitReads();
	checkCount("responses", lpMasterNum, order.size());
	for (int i = 0; i < lpMasterNum; i++)
		checkMaster("response order", ufiMaster_e'(i), order[i]);
	waitCredits();
endtask

task automatic testRoundRobin();
	ufiMaster_e                 m;
	logic [lpMasterIdWidth-1:0] nxt;
	curTest = "round robin";
	writeCfg(1'b1, 4'b0001);
	order.delete();
	repeat (lpCreditNum)
	begin
		for (int i = 0; i < lpMasterNum; i++)
		begin
			m = ufiMaster_e'(i);
			stageReq(m, opRead, {m, 8'h20}, '0);
		end
		driveCycle();
	end
	waitReads();
	checkCount("responses", lpCreditNum * lpMasterNum, order.size());
	for (int i = 1; i < order.size(); i++)
	begin
		nxt = order[i-1] + 1'b1;   // Rotation wraps atb to mcs
		checkMaster("rotation", ufiMaster_e'(nxt), order[i]);
	end
	waitCredits();

	// Masking atb holds its read
	curTest = "enable mask";
	writeCfg(1'b0, 4'b0111);
	checkCfg(4'b0111, arbRoundRobin);
	stageReq(atbM, opRead, {atbM, 8'h20}, '0);
	driveCycle();
	repeat (lpHoldCycles)
	begin
		idleCycle();
		processRsps();
	end
	checkCount("atb reads held", 1, expQ[atbM].size());
	checkCredit(atbM, lpCreditNum - 1);
	writeCfg(1'b0, '1);
	waitReads();
	waitCredits();
	writeCfg(1'b1, '0);
endtask

task automatic testRandom();
	ufiMaster_e             m;
	logic [lpAdrsWidth-1:0] a;
	logic [2:0]             lo;
	int                     sent;
	curTest = "random traffic";
	sent    = 0;
	while (sent < lpRandReqs)
	begin
		for (int i = 0; i < lpMasterNum; i++)
		begin
			m = ufiMaster_e'(i);
			if (sent < lpRandReqs && creditsHeld(m) > 0 && randBits(1) == 1)
			begin
				lo = 3'(randBits(3));
				a  = {m, 5'd0, lo};   // Eight words per master
				if (randBits(1) == 1 || !written[a])
					stageReq(m, opWrite, a, lpDataWidth'(randBits(lpDataWidth)));
				else
					stageReq(m, opRead, a, '0);
				sent++;
			end
		end
		driveCycle();
		processRsps();
	end
	waitReads();
	waitCredits();
endtask

`endif

//--- test/ufiHubTb.sv
// Hub testbench; masters follow the credit rule, every read address is written first, Verilator --timing
`timescale 1ns/1ns

module ufiHubTb
	import ufiPkg::*;
;

	//--------------------------------------------------
	// Timing and test sizes
	//--------------------------------------------------
	localparam int lpClkHalf     = 10;   // 20 ns period
	localparam int lpResetCycles = 8;
	localparam int lpDriveDelay  = 2;    // After rising edge
	localparam int lpWaitCycles  = 40;   // Bound on any wait loop
	localparam int lpHoldCycles  = 16;   // Disabled master check window
	localparam int lpSeed        = 65742;

	// Requests per test, sum feeds the watchdog
	localparam int lpUncontReqs = 2 * lpMasterNum;              // Write then read each
	localparam int lpCreditReqs = lpCreditNum;
	localparam int lpFixedReqs  = 2 * lpMasterNum;
	localparam int lpRrReqs     = lpCreditNum * lpMasterNum + 1; // Plus held atb read
	localparam int lpRandReqs   = 64;
	localparam int lpTotalReqs  = lpUncontReqs + lpCreditReqs + lpFixedReqs + lpRrReqs
	                              + lpRandReqs;
	localparam int lpWatchdogNs = lpTotalReqs * 20 * 2 * lpClkHalf;

	// One logged read response
	typedef struct packed {
		ufiMaster_e m;
		ufiRsp_t    rsp;
		int         edgeNo;   // Edge count when seen
	} rspRec_t;

	//--------------------------------------------------
	// DUT signals
	//--------------------------------------------------
	logic                   iUfiClk = 1'b0;
	logic                   rstN;
	ufiReq_t                mReq [lpMasterNum];
	logic [lpMasterNum-1:0] mCredit;
	ufiRsp_t                mRsp [lpMasterNum];
	ufiCfgWr_t              cfgWr;
	logic [lpMasterNum-1:0] cfgEnable;
	ufiArbMode_e            cfgMode;

	//--------------------------------------------------
	// Master models and scoreboard
	//--------------------------------------------------
	ufiReq_t                reqNext [lpMasterNum];       // Staged for next drive
	int                     spent [lpMasterNum];         // Requests sent
	int                     creditRet [lpMasterNum];     // Credit pulses seen
	logic [lpDataWidth-1:0] expQ [lpMasterNum][$];       // Expected read data
	int                     lastEdge [lpMasterNum];      // Edge of last response
	logic [lpDataWidth-1:0] shadow [lpRamDepth];         // Expected RAM contents
	bit                     written [lpRamDepth];
	rspRec_t                rspLog [lpTotalReqs];        // Filled by monitor
	int                     rspCnt;
	int                     rspSeen;                     // Consumed by tests
	ufiMaster_e             order [$];                   // Response order
	int                     edgeCnt;
	int                     drvEdge;                     // Edge sampling last drive
	logic [31:0]            lfsr = 32'(lpSeed);
	string                  curTest = "none";

	`include "ufiHubTasks.svh"

	ufiHub ufiHub_inst (
		.iUfiClk   (iUfiClk),
		.rstN      (rstN),
		.mReq      (mReq),
		.mCredit   (mCredit),
		.mRsp      (mRsp),
		.cfgWr     (cfgWr),
		.cfgEnable (cfgEnable),
		.cfgMode   (cfgMode)
	);

	always #lpClkHalf iUfiClk = ~iUfiClk;

	always @(posedge iUfiClk)
		edgeCnt++;

	//--------------------------------------------------
	// Monitor, samples on the falling edge
	//--------------------------------------------------
	always @(negedge iUfiClk)
	begin
		rspRec_t rec;
		for (int i = 0; i < lpMasterNum; i++)
		begin
			if (mCredit[i])
			begin
				if (creditRet[i] >= spent[i])
					failRun($sformatf("%s: credit pulse on master %0d with no request out",
						curTest, i));
				else
					creditRet[i]++;
			end
			if (mRsp[i].valid)
			begin
				if (rspCnt >= lpTotalReqs)
					failRun("More read responses than requests were sent");
				rec.m      = ufiMaster_e'(i);
				rec.rsp    = mRsp[i];
				rec.edgeNo = edgeCnt;
				rspLog[rspCnt] = rec;   // Checked by the test process
				rspCnt++;
			end
		end
	end

	// Watchdog
	initial
	begin
		#lpWatchdogNs;
		failRun("Watchdog expired before the tests finished");
	end

	//--------------------------------------------------
	// Test sequence
	//--------------------------------------------------
	initial
	begin
		rstN  = 1'b0;
		cfgWr = '0;
		for (int i = 0; i < lpMasterNum; i++)
		begin
			mReq[i]    = '0;
			reqNext[i] = '0;
		end
		repeat (lpResetCycles) @(posedge iUfiClk);
		#lpDriveDelay;
		rstN = 1'b1;

		testReset();
		testUncontended();
		testCredit();
		testFixed();
		testRoundRobin();
		testRandom();

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- ufiHub.f
+incdir+test
hdl/ufiPkg.sv
hdl/ufiConfigRegs.sv
hdl/ufiReqQueue.sv
hdl/ufiArbiter.sv
hdl/ufiRamSlave.sv
hdl/ufiReadRouter.sv
hdl/ufiHub.sv
test/ufiHubTb.sv
